// File: common/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Core geometry
`define CORE_WARPS 2
`define CORE_THREADS 4

// Word and address widths
`define CORE_DATA_WIDTH 32
`define CORE_IADDR_WIDTH 8
`define CORE_DADDR_WIDTH 8

// Registers per file, register 0 reads zero
`define CORE_REGS 16

`endif

// File: common/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_DATA_WIDTH-1:0] data_t;
    typedef logic [`CORE_IADDR_WIDTH-1:0] iaddr_t;
    typedef logic [`CORE_DADDR_WIDTH-1:0] daddr_t;
    typedef logic [$clog2(`CORE_REGS)-1:0] reg_idx_t;
    typedef logic [$clog2(`CORE_WARPS)-1:0] warp_idx_t;
    typedef logic [$clog2(`CORE_WARPS+1)-1:0] warp_count_t;

    typedef enum logic [2:0] {
        ADD   = 3'd0,
        SUB   = 3'd1,
        AND   = 3'd2,
        ADDI  = 3'd3,
        TID   = 3'd4,
        BNEZ  = 3'd5,
        STORE = 3'd6,
        HALT  = 3'd7
    } opcode_e;

    // Register form: rd = rs1 op rs2
    typedef struct packed {
        opcode_e     opcode;
        logic        scalar;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [15:0] pad;
    } instr_reg_t;

    // Immediate form with a 20-bit signed immediate
    typedef struct packed {
        opcode_e     opcode;
        logic        scalar;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [19:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef struct packed {
        opcode_e  opcode;
        logic     scalar;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
        logic     reg_write;
        logic     store;
        logic     halt;
    } decoded_t;

    typedef struct packed {
        iaddr_t      base_iaddr;
        warp_count_t num_warps;
    } kernel_config_t;

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, REQUEST, WAIT, EXECUTE, UPDATE, DONE
    } warp_state_e;

    typedef struct packed {
        logic   valid;
        iaddr_t addr;
    } imem_req_t;

    typedef struct packed {
        logic   valid;
        daddr_t addr;
        data_t  data;
    } dmem_write_t;

    // Integer operation shared by the lane ALUs and the scalar ALU
    function automatic data_t alu_result(decoded_t d, data_t op1, data_t op2, data_t tid);
        case (d.opcode)
            ADD:     return op1 + op2;
            SUB:     return op1 - op2;
            AND:     return op1 & op2;
            ADDI:    return op1 + d.imm;
            TID:     return tid;
            // Branch test looks at rs1 alone
            BNEZ:    return op1;
            default: return '0;
        endcase
    endfunction

endpackage

// File: compute_core.f
+incdir+common
common/core_pkg.sv
rtl/fetcher.sv
rtl/decoder.sv
warp_scheduler/warp_scheduler.sv
rtl/warp_reg_file.sv
rtl/lane_unit.sv
rtl/compute_core.sv
testbench/compute_core_tb.sv

// File: rtl/compute_core.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module compute_core (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  core_pkg::kernel_config_t                kernel_config,
    output logic                                    done,
    output core_pkg::imem_req_t [`CORE_WARPS-1:0]   imem_req,
    input  logic [`CORE_WARPS-1:0]                  imem_ready,
    input  core_pkg::instr_t [`CORE_WARPS-1:0]      imem_data,
    output core_pkg::dmem_write_t [`CORE_THREADS-1:0] dmem_write,
    input  logic [`CORE_THREADS-1:0]                dmem_ready
);
    core_pkg::warp_state_e                  warp_state [`CORE_WARPS];
    core_pkg::iaddr_t [`CORE_WARPS-1:0]     pc;
    core_pkg::warp_idx_t                    current_warp;
    logic [`CORE_WARPS-1:0]                 fetch_done;
    core_pkg::instr_t [`CORE_WARPS-1:0]     instruction;
    core_pkg::decoded_t [`CORE_WARPS-1:0]   decoded;
    core_pkg::data_t [`CORE_WARPS-1:0]      scalar_rs1;
    core_pkg::data_t [`CORE_WARPS-1:0]      scalar_rs2;
    core_pkg::data_t [`CORE_WARPS-1:0][`CORE_THREADS-1:0] vector_rs1;
    core_pkg::data_t [`CORE_WARPS-1:0][`CORE_THREADS-1:0] vector_rs2;
    core_pkg::data_t [`CORE_THREADS-1:0]    lane_results;
    logic [`CORE_THREADS-1:0]               lanes_busy;
    core_pkg::data_t                        scalar_result;
    core_pkg::decoded_t                     cur_decoded;
    core_pkg::warp_state_e                  cur_state;

    assign cur_decoded = decoded[current_warp];
    assign cur_state   = warp_state[current_warp];

    warp_scheduler i_scheduler (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .kernel_config (kernel_config),
        .fetch_done    (fetch_done),
        .decoded       (cur_decoded),
        .lanes_busy    (lanes_busy),
        .scalar_result (scalar_result),
        .warp_state    (warp_state),
        .pc            (pc),
        .current_warp  (current_warp),
        .done          (done)
    );

    for (genvar w = 0; w < `CORE_WARPS; w++) begin : g_warp
        fetcher i_fetcher (
            .clk         (clk),
            .reset       (reset),
            .warp_state  (warp_state[w]),
            .pc          (pc[w]),
            .imem_ready  (imem_ready[w]),
            .imem_data   (imem_data[w]),
            .imem_req    (imem_req[w]),
            .fetch_done  (fetch_done[w]),
            .instruction (instruction[w])
        );

        decoder i_decoder (
            .clk         (clk),
            .reset       (reset),
            .warp_state  (warp_state[w]),
            .instruction (instruction[w]),
            .decoded     (decoded[w])
        );

        // Only the scheduled warp writes, once, in EXECUTE
        warp_reg_file i_reg_file (
            .clk           (clk),
            .reset         (reset),
            .write_enable  (current_warp == w && warp_state[w] == core_pkg::EXECUTE
                            && decoded[w].reg_write),
            .scalar        (decoded[w].scalar),
            .rd            (decoded[w].rd),
            .rs1           (decoded[w].rs1),
            .rs2           (decoded[w].rs2),
            .scalar_result (scalar_result),
            .lane_results  (lane_results),
            .scalar_rs1    (scalar_rs1[w]),
            .scalar_rs2    (scalar_rs2[w]),
            .vector_rs1    (vector_rs1[w]),
            .vector_rs2    (vector_rs2[w])
        );
    end

    // Lanes are shared and follow the current warp
    for (genvar l = 0; l < `CORE_THREADS; l++) begin : g_lane
        lane_unit #(
            .LANE (l)
        ) i_lane (
            .clk        (clk),
            .reset      (reset),
            .warp_index (current_warp),
            .decoded    (cur_decoded),
            .warp_state (cur_state),
            .op1        (vector_rs1[current_warp][l]),
            .op2        (vector_rs2[current_warp][l]),
            .result     (lane_results[l]),
            .busy       (lanes_busy[l]),
            .dmem_ready (dmem_ready[l]),
            .dmem_write (dmem_write[l])
        );
    end

    // Scalar ALU, TID gives the warp index here
    assign scalar_result = core_pkg::alu_result(cur_decoded, scalar_rs1[current_warp],
                                                scalar_rs2[current_warp],
                                                core_pkg::data_t'(current_warp));

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ns

module decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::warp_state_e warp_state,
    input  core_pkg::instr_t      instruction,
    output core_pkg::decoded_t    decoded
);
    core_pkg::opcode_e  opcode;
    core_pkg::data_t    imm_ext;
    core_pkg::decoded_t next;

    assign opcode  = instruction.r.opcode;
    assign imm_ext = core_pkg::data_t'(signed'(instruction.i.imm));

    always_comb begin
        next        = '0;
        next.opcode = opcode;
        next.scalar = instruction.r.scalar;
        next.rd     = instruction.r.rd;
        next.rs1    = instruction.r.rs1;
        case (opcode)
            core_pkg::ADD, core_pkg::SUB, core_pkg::AND: begin
                next.rs2       = instruction.r.rs2;
                next.reg_write = 1'b1;
            end
            core_pkg::ADDI: begin
                next.imm       = imm_ext;
                next.reg_write = 1'b1;
            end
            core_pkg::TID: next.reg_write = 1'b1;
            core_pkg::BNEZ: next.imm = imm_ext;
            core_pkg::STORE: begin
                // Data register travels in the rd field
                next.rs2    = instruction.i.rd;
                next.rd     = '0;
                next.scalar = 1'b0;
                next.imm    = imm_ext;
                next.store  = 1'b1;
            end
            core_pkg::HALT: next.halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (warp_state == core_pkg::DECODE) begin
            decoded <= next;
        end
    end

endmodule

// File: rtl/fetcher.sv
`timescale 1ns/1ns

module fetcher (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::warp_state_e warp_state,
    input  core_pkg::iaddr_t      pc,
    input  logic                  imem_ready,
    input  core_pkg::instr_t      imem_data,
    output core_pkg::imem_req_t   imem_req,
    output logic                  fetch_done,
    output core_pkg::instr_t      instruction
);
    typedef enum logic [1:0] {F_IDLE, F_REQUEST, F_DONE} fetch_state_e;

    fetch_state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= F_IDLE;
            imem_req.valid <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (warp_state == core_pkg::FETCH) begin
                        state          <= F_REQUEST;
                        imem_req.valid <= 1'b1;
                        imem_req.addr  <= pc;
                    end
                end
                F_REQUEST: begin
                    if (imem_ready) begin
                        state          <= F_DONE;
                        imem_req.valid <= 1'b0;
                        instruction    <= imem_data;
                    end
                end
                default: begin
                    // Hold until the scheduler moves the warp on
                    if (warp_state != core_pkg::FETCH) begin
                        state <= F_IDLE;
                    end
                end
            endcase
        end
    end

    // Done already in the handshake cycle, so the warp decodes next
    assign fetch_done = (state == F_REQUEST && imem_ready) || state == F_DONE;

    // Request stays on the warp's pc while the warp waits in FETCH
    assert property (@(posedge clk) disable iff (reset)
        imem_req.valid |-> warp_state == core_pkg::FETCH && imem_req.addr == pc);

endmodule

// File: rtl/lane_unit.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module lane_unit #(
    parameter int LANE = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::warp_idx_t   warp_index,
    input  core_pkg::decoded_t    decoded,
    input  core_pkg::warp_state_e warp_state,
    input  core_pkg::data_t       op1,
    input  core_pkg::data_t       op2,
    output core_pkg::data_t       result,
    output logic                  busy,
    input  logic                  dmem_ready,
    output core_pkg::dmem_write_t dmem_write
);
    core_pkg::data_t  global_tid;
    logic             store_req;
    logic             store_valid;
    core_pkg::daddr_t store_addr;
    core_pkg::data_t  store_data;

    assign global_tid = core_pkg::data_t'(warp_index) * `CORE_THREADS + LANE;
    assign result     = core_pkg::alu_result(decoded, op1, op2, global_tid);
    assign store_req  = warp_state == core_pkg::REQUEST && decoded.store;

    always_ff @(posedge clk) begin
        if (reset) begin
            store_valid <= 1'b0;
        end else if (store_req) begin
            store_valid <= 1'b1;
        end else if (dmem_ready) begin
            store_valid <= 1'b0;
        end
    end

    // Address wraps to the data address width
    always_ff @(posedge clk) begin
        if (store_req) begin
            store_addr <= core_pkg::daddr_t'(op1 + decoded.imm);
            store_data <= op2;
        end
    end

    assign busy       = store_valid;
    assign dmem_write = '{valid: store_valid, addr: store_addr, data: store_data};

    assert property (@(posedge clk) disable iff (reset)
        store_valid && !dmem_ready |=>
            store_valid && $stable(store_addr) && $stable(store_data));

endmodule

// File: rtl/warp_reg_file.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module warp_reg_file (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  write_enable,
    input  logic                                  scalar,
    input  core_pkg::reg_idx_t                    rd,
    input  core_pkg::reg_idx_t                    rs1,
    input  core_pkg::reg_idx_t                    rs2,
    input  core_pkg::data_t                       scalar_result,
    input  core_pkg::data_t [`CORE_THREADS-1:0]   lane_results,
    output core_pkg::data_t                       scalar_rs1,
    output core_pkg::data_t                       scalar_rs2,
    output core_pkg::data_t [`CORE_THREADS-1:0]   vector_rs1,
    output core_pkg::data_t [`CORE_THREADS-1:0]   vector_rs2
);
    core_pkg::data_t                     scalar_regs [`CORE_REGS];
    // One row per register, one word per lane
    core_pkg::data_t [`CORE_THREADS-1:0] vector_regs [`CORE_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `CORE_REGS; r++) begin
                scalar_regs[r] <= '0;
                vector_regs[r] <= '0;
            end
        end else if (write_enable && rd != '0) begin
            if (scalar) begin
                scalar_regs[rd] <= scalar_result;
            end else begin
                vector_regs[rd] <= lane_results;
            end
        end
    end

    assign scalar_rs1 = scalar_regs[rs1];
    assign scalar_rs2 = scalar_regs[rs2];
    assign vector_rs1 = vector_regs[rs1];
    assign vector_rs2 = vector_regs[rs2];

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module compute_core_tb \
    -f compute_core.f -o compute_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/compute_core_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: testbench/compute_core_tb.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module compute_core_tb;

    localparam int TEST_COUNT = 7;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int CYCLE_LIMIT = TEST_COUNT * CYCLES_PER_TEST;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic start = 1'b0;
    core_pkg::kernel_config_t kernel_config = '0;
    logic done;
    core_pkg::imem_req_t [`CORE_WARPS-1:0] imem_req;
    logic [`CORE_WARPS-1:0] imem_ready = '0;
    core_pkg::instr_t [`CORE_WARPS-1:0] imem_data = '0;
    core_pkg::dmem_write_t [`CORE_THREADS-1:0] dmem_write;
    logic [`CORE_THREADS-1:0] dmem_ready = '0;

    logic backpressure = 1'b0;
    logic [31:0] lfsr = 32'hcde24fe3;
    int cycle_count = 0;
    core_pkg::instr_t prog [`CORE_WARPS][256];
    // Accepted writes per lane in address order
    core_pkg::dmem_write_t lane_writes [`CORE_THREADS][$];

    compute_core i_compute_core (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .kernel_config (kernel_config),
        .done          (done),
        .imem_req      (imem_req),
        .imem_ready    (imem_ready),
        .imem_data     (imem_data),
        .dmem_write    (dmem_write),
        .dmem_ready    (dmem_ready)
    );

    always #50 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return b;
    endfunction

    function automatic core_pkg::instr_t reg_instr(core_pkg::opcode_e op, logic scalar,
                                                   logic [3:0] rd, logic [3:0] rs1,
                                                   logic [3:0] rs2);
        return {op, scalar, rd, rs1, rs2, 16'h0000};
    endfunction

    function automatic core_pkg::instr_t imm_instr(core_pkg::opcode_e op, logic scalar,
                                                   logic [3:0] rd, logic [3:0] rs1, int imm);
        return {op, scalar, rd, rs1, imm[19:0]};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input core_pkg::data_t expected,
                              input core_pkg::data_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("error %s: expected 0x%08h, actual 0x%08h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input core_pkg::daddr_t expected,
                              input core_pkg::daddr_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("error %s: expected address 0x%02h, actual 0x%02h",
                                    name, expected, actual));
        end
    endtask

    // Instruction and data memories answer 1 ns after the edge
    always @(posedge clk) begin
        #1;
        for (int w = 0; w < `CORE_WARPS; w++) begin
            imem_ready[w] = backpressure ? lfsr_bit() : 1'b1;
            imem_data[w]  = prog[w][imem_req[w].addr];
        end
        for (int l = 0; l < `CORE_THREADS; l++) begin
            dmem_ready[l] = backpressure ? lfsr_bit() : 1'b1;
        end
    end

    // Valid and ready are both settled at the falling edge
    always @(negedge clk) begin
        int pos;
        if (reset) begin
            for (int l = 0; l < `CORE_THREADS; l++) begin
                lane_writes[l].delete();
            end
        end else begin
            for (int l = 0; l < `CORE_THREADS; l++) begin
                if (dmem_write[l].valid && dmem_ready[l]) begin
                    pos = 0;
                    while (pos < lane_writes[l].size()
                            && lane_writes[l][pos].addr < dmem_write[l].addr) begin
                        pos++;
                    end
                    lane_writes[l].insert(pos, dmem_write[l]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout: no result after %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset(input logic bp);
        reset = 1'b1;
        start = 1'b0;
        backpressure = bp;
        repeat (8) next_cycle();
        reset = 1'b0;
    endtask

    // Unused words hold HALT with the address in the immediate
    task automatic clear_programs();
        for (int w = 0; w < `CORE_WARPS; w++) begin
            for (int a = 0; a < 256; a++) begin
                prog[w][a] = imm_instr(core_pkg::HALT, 1'b0, 4'd0, 4'd0, a);
            end
        end
    endtask

    task automatic launch(input core_pkg::iaddr_t base, input int warps);
        kernel_config.base_iaddr = base;
        kernel_config.num_warps  = core_pkg::warp_count_t'(warps);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            next_cycle();
        end
    endtask

    task automatic expect_quiet(input string name, input logic expect_done);
        if (done !== expect_done) begin
            stop_on_error($sformatf("error %s: done expected %b, actual %b",
                                    name, expect_done, done));
        end
        for (int w = 0; w < `CORE_WARPS; w++) begin
            if (imem_req[w].valid !== 1'b0) begin
                stop_on_error($sformatf("%s: warp %0d raised an instruction request", name, w));
            end
        end
        for (int l = 0; l < `CORE_THREADS; l++) begin
            if (dmem_write[l].valid !== 1'b0) begin
                stop_on_error($sformatf("%s: lane %0d raised a data write", name, l));
            end
        end
    endtask

    // Thread tid writes mult * (tid + add) to offset + tid exactly once
    task automatic verify_stores(input string name, input int warps, input int offset,
                                 input int mult, input int add);
        int tid;
        core_pkg::dmem_write_t wr;
        for (int l = 0; l < `CORE_THREADS; l++) begin
            if (lane_writes[l].size() != warps) begin
                stop_on_error($sformatf(
                    "error %s: lane %0d accepted writes expected %0d, actual %0d",
                    name, l, warps, lane_writes[l].size()));
            end
            for (int k = 0; k < warps; k++) begin
                tid = k * `CORE_THREADS + l;
                wr  = lane_writes[l][k];
                check_addr(name, core_pkg::daddr_t'(offset + tid), wr.addr);
                check_data(name, core_pkg::data_t'(mult * (tid + add)), wr.data);
            end
        end
    endtask

    task automatic load_straight(input int w, input int base);
        prog[w][base]     = imm_instr(core_pkg::TID, 1'b0, 4'd1, 4'd0, 0);
        prog[w][base + 1] = imm_instr(core_pkg::ADDI, 1'b0, 4'd2, 4'd1, 5);
        prog[w][base + 2] = reg_instr(core_pkg::ADD, 1'b0, 4'd3, 4'd2, 4'd2);
        // Data register sits in the rd field
        prog[w][base + 3] = imm_instr(core_pkg::STORE, 1'b0, 4'd3, 4'd1, 16);
        prog[w][base + 4] = imm_instr(core_pkg::HALT, 1'b0, 4'd0, 4'd0, 0);
    endtask

    task automatic reset_test();
        apply_reset(1'b0);
        repeat (10) begin
            expect_quiet("reset", 1'b0);
            next_cycle();
        end
    endtask

    task automatic straight_test();
        apply_reset(1'b0);
        clear_programs();
        load_straight(0, 8'h10);
        launch(8'h10, 1);
        wait_done();
        verify_stores("straight", 1, 16, 2, 5);
    endtask

    task automatic two_warp_test(input logic bp);
        string name;
        name = bp ? "two_warps_bp" : "two_warps";
        apply_reset(bp);
        clear_programs();
        for (int w = 0; w < `CORE_WARPS; w++) begin
            prog[w][8'h40] = imm_instr(core_pkg::TID, 1'b0, 4'd1, 4'd0, 0);
            prog[w][8'h41] = imm_instr(core_pkg::STORE, 1'b0, 4'd1, 4'd1, 32);
            prog[w][8'h42] = imm_instr(core_pkg::HALT, 1'b0, 4'd0, 4'd0, 0);
        end
        launch(8'h40, 2);
        wait_done();
        verify_stores(name, 2, 32, 1, 0);
    endtask

    task automatic loop_test(input logic bp);
        string name;
        name = bp ? "loop_bp" : "loop";
        apply_reset(bp);
        clear_programs();
        for (int w = 0; w < `CORE_WARPS; w++) begin
            prog[w][8'h80] = imm_instr(core_pkg::ADDI, 1'b1, 4'd1, 4'd0, 3);
            prog[w][8'h81] = imm_instr(core_pkg::TID, 1'b0, 4'd1, 4'd0, 0);
            // Loop body accumulates tid into v2
            prog[w][8'h82] = reg_instr(core_pkg::ADD, 1'b0, 4'd2, 4'd2, 4'd1);
            prog[w][8'h83] = imm_instr(core_pkg::ADDI, 1'b1, 4'd1, 4'd1, -1);
            prog[w][8'h84] = imm_instr(core_pkg::BNEZ, 1'b1, 4'd0, 4'd1, -2);
            prog[w][8'h85] = imm_instr(core_pkg::STORE, 1'b0, 4'd2, 4'd1, 64);
            prog[w][8'h86] = imm_instr(core_pkg::HALT, 1'b0, 4'd0, 4'd0, 0);
        end
        launch(8'h80, 2);
        wait_done();
        verify_stores(name, 2, 64, 3, 0);
    endtask

    task automatic halt_test();
        apply_reset(1'b0);
        clear_programs();
        load_straight(0, 8'h10);
        launch(8'h10, 1);
        wait_done();
        repeat (20) begin
            expect_quiet("halt", 1'b1);
            next_cycle();
        end
        // Second start while running must change nothing
        launch(8'h10, 1);
        repeat (20) begin
            expect_quiet("halt_restart", 1'b1);
            next_cycle();
        end
    endtask

    initial begin
        reset_test();
        straight_test();
        two_warp_test(1'b0);
        loop_test(1'b0);
        two_warp_test(1'b1);
        loop_test(1'b1);
        halt_test();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: warp_scheduler/warp_scheduler.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module warp_scheduler (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  core_pkg::kernel_config_t        kernel_config,
    input  logic [`CORE_WARPS-1:0]          fetch_done,
    input  core_pkg::decoded_t              decoded,
    input  logic [`CORE_THREADS-1:0]        lanes_busy,
    input  core_pkg::data_t                 scalar_result,
    output core_pkg::warp_state_e           warp_state [`CORE_WARPS],
    output core_pkg::iaddr_t [`CORE_WARPS-1:0] pc,
    output core_pkg::warp_idx_t             current_warp,
    output logic                            done
);
    logic                  running;
    logic                  all_done;
    core_pkg::warp_count_t num_warps;
    core_pkg::iaddr_t      next_pc;
    core_pkg::warp_idx_t   next_warp;
    core_pkg::warp_state_e cur_state;

    assign cur_state = warp_state[current_warp];

    // All active warps halted
    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < `CORE_WARPS; i++) begin
            if (i < num_warps && warp_state[i] != core_pkg::DONE) begin
                all_done = 1'b0;
            end
        end
    end

    // Round robin from the warp after the current one, current one last
    always_comb begin
        int   idx;
        logic found;
        next_warp = current_warp;
        found     = 1'b0;
        for (int i = 1; i <= `CORE_WARPS; i++) begin
            idx = (int'(current_warp) + i) % `CORE_WARPS;
            if (!found && warp_state[idx] >= core_pkg::DECODE
                    && warp_state[idx] <= core_pkg::UPDATE) begin
                next_warp = core_pkg::warp_idx_t'(idx);
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running      <= 1'b0;
            done         <= 1'b0;
            num_warps    <= '0;
            current_warp <= '0;
            next_pc      <= '0;
            for (int i = 0; i < `CORE_WARPS; i++) begin
                warp_state[i] <= core_pkg::IDLE;
                pc[i]         <= '0;
            end
        end else if (!running) begin
            if (start) begin
                running      <= 1'b1;
                num_warps    <= kernel_config.num_warps;
                current_warp <= '0;
                for (int i = 0; i < `CORE_WARPS; i++) begin
                    if (i < kernel_config.num_warps) begin
                        warp_state[i] <= core_pkg::FETCH;
                        pc[i]         <= kernel_config.base_iaddr;
                    end
                end
            end
        end else begin
            done <= done | all_done;

            // Fetches complete in parallel for every warp
            for (int i = 0; i < `CORE_WARPS; i++) begin
                if (warp_state[i] == core_pkg::FETCH && fetch_done[i]) begin
                    warp_state[i] <= core_pkg::DECODE;
                end
            end

            if (cur_state inside {core_pkg::IDLE, core_pkg::FETCH, core_pkg::DONE}) begin
                current_warp <= next_warp;
            end

            case (cur_state)
                core_pkg::DECODE: warp_state[current_warp] <= core_pkg::REQUEST;
                core_pkg::REQUEST: warp_state[current_warp] <= core_pkg::WAIT;
                core_pkg::WAIT: begin
                    if (!(|lanes_busy)) begin
                        warp_state[current_warp] <= core_pkg::EXECUTE;
                    end
                end
                core_pkg::EXECUTE: begin
                    if (decoded.opcode == core_pkg::BNEZ && scalar_result != '0) begin
                        next_pc <= pc[current_warp] + core_pkg::iaddr_t'(decoded.imm);
                    end else begin
                        next_pc <= pc[current_warp] + 1'b1;
                    end
                    warp_state[current_warp] <= core_pkg::UPDATE;
                end
                core_pkg::UPDATE: begin
                    if (decoded.halt) begin
                        warp_state[current_warp] <= core_pkg::DONE;
                    end else begin
                        pc[current_warp]         <= next_pc;
                        warp_state[current_warp] <= core_pkg::FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        running |-> current_warp < num_warps);

endmodule
